/* hw/fp32Pkg.sv */
// Single-precision float package holding the IEEE 754 word layout and its constants
`default_nettype none

package fp32Pkg;

	// ========================================
	// Field boundaries
	// ========================================

	// Top bit index of the biased exponent field
	localparam int EMSB = 7;

	// Top bit index of the stored fraction field
	localparam int FMSB = 22;

	// ========================================
	// Exponent constants
	// ========================================

	// Biased exponent of the value one
	// An exponent below this marks a magnitude smaller than one
	localparam int expBias = 127;

	// All-ones exponent shared by infinities and NaNs
	// A zero fraction means infinity and anything else is a NaN
	localparam int expMax = 255;

	// ========================================
	// Word layout
	// ========================================

	// One float word with the sign in bit 31, the exponent in bits 30 to 23
	// and the fraction in bits 22 to 0
	// The hidden one is not stored and is restored by whoever needs the significand
	typedef struct packed {
		logic          sign;
		logic [EMSB:0] exp;
		logic [FMSB:0] sig;
	} FP32;

endpackage

`default_nettype wire

/* hw/cvtPkg.sv */
// Conversion package with the operation select and the exception flag layout
`default_nettype none

package cvtPkg;

	// ========================================
	// Operation select
	// ========================================

	// Chooses which of the two parallel paths delivers the result
	// Both paths always run, so this only steers the combining stage
	typedef enum logic {
		// Round toward zero while staying in float format
		opTrunc = 1'b0,
		// Round toward zero into a saturated signed integer
		opToInt = 1'b1
	} cvtOp_e;

	// ========================================
	// Exception flags
	// ========================================

	// Flags raised by one conversion
	// The same layout is used for the per-result flags and the sticky copy
	typedef struct packed {
		// Operand was a NaN
		logic invalid;
		// Integer result was clamped to its largest or smallest value
		logic overflow;
		// Nonzero fraction bits were discarded
		logic inexact;
	} cvtFlags_t;

	// Width of the raw result word carried by every path
	// An integer narrower than this is sign extended into it
	localparam int resWidth = 32;

endpackage

`default_nettype wire

/* hw/cvtResultIf.sv */
// Result bus that carries one conversion path's registered output to the combining stage
`default_nettype none

interface cvtResultIf import cvtPkg::*; ();

	// Raw result word, either a float or a sign-extended integer
	logic [resWidth-1:0] res;

	// Flags that belong to this result
	cvtFlags_t           flags;

	// High for one enabled cycle per accepted operand
	logic                vld;

	// Operation requested with the operand, passed along with the result
	cvtOp_e              op;

	// Driving side, owned by a conversion path
	modport src (output res, output flags, output vld, output op);

	// Receiving side, owned by the combining stage
	modport dst (input res, input flags, input vld, input op);

endinterface

`default_nettype wire

/* hw/fpTrunc32.sv */
// Float truncation path that chops fraction bits below the binary point and stays in float format
`default_nettype none

module fpTrunc32 import fp32Pkg::*, cvtPkg::*; (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   ce,
	input  wire logic   inVld,
	input  wire cvtOp_e op,
	input  wire FP32    operand,
	cvtResultIf.src     out
);

	// Operand fields
	logic          opSign;
	logic [EMSB:0] opExp;
	logic [FMSB:0] opSig;

	// Number of fraction bits that lie below the binary point
	logic [4:0]    dropBits;
	logic [FMSB:0] fracMask;

	logic          isNan;
	logic          belowOne;
	logic          noFraction;

	FP32           truncVal;
	cvtFlags_t     truncFlags;

	assign opSign = operand.sign;
	assign opExp  = operand.exp;
	assign opSig  = operand.sig;

	assign isNan      = (int'(opExp) == expMax) && (opSig != '0);
	assign belowOne   = opExp < expBias;
	// From exponent 150 upward every stored bit is already an integer bit
	assign noFraction = opExp > expBias + FMSB;

	// Exponent 127 drops all 23 bits and exponent 149 drops only the last one
	assign dropBits = 5'(expBias + FMSB + 1 - int'(opExp));
	assign fracMask = {(FMSB + 1){1'b1}} << dropBits;

	// ========================================
	// Truncation
	// ========================================

	always_comb begin
		truncVal   = operand;
		truncFlags = '0;
		if (belowOne) begin
			// Magnitudes below one become a zero of the same sign
			// Denormals land here as well and count as lost fraction
			truncVal      = '0;
			truncVal.sign = opSign;
			truncFlags.inexact = (opExp != '0) || (opSig != '0);
		end else if (!noFraction) begin
			truncVal.sig       = opSig & fracMask;
			truncFlags.inexact = (opSig & ~fracMask) != '0;
		end else begin
			// Large values, infinities and NaNs pass through untouched
			truncFlags.invalid = isNan;
		end
	end

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			out.vld <= 1'b0;
		end else if (ce) begin
			out.vld <= inVld;
		end
	end

	// Payload only loads for an accepted operand
	always_ff @(posedge clk) begin
		if (ce && inVld) begin
			out.res   <= truncVal;
			out.flags <= truncFlags;
			out.op    <= op;
		end
	end

	// The valid bit must come out of reset cleared
	validAfterReset: assert property (@(posedge clk) rst |=> !out.vld)
		else $error("truncation path valid set after reset");

endmodule

`default_nettype wire

/* hw/fpToInt.sv */
// Float to signed integer path that rounds toward zero and saturates out-of-range values
`default_nettype none

module fpToInt import fp32Pkg::*, cvtPkg::*; #(
	parameter int intWidth = 32
) (
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire logic   ce,
	input  wire logic   inVld,
	input  wire cvtOp_e op,
	input  wire FP32    operand,
	cvtResultIf.src     out
);

	// Biased exponent of 2 to the power intWidth-1 as the first magnitude that no longer fits
	localparam int topExp = expBias + intWidth - 1;

	// Saturation limits
	localparam logic [intWidth-1:0] maxPos = {1'b0, {(intWidth - 1){1'b1}}};
	localparam logic [intWidth-1:0] minNeg = {1'b1, {(intWidth - 1){1'b0}}};

	logic          opSign;
	logic [EMSB:0] opExp;
	logic [FMSB:0] opSig;

	// Significand as a fixed-point value with FMSB+1 fraction bits
	logic [5:0]                 shiftAmt;
	logic [63:0]                fixedVal;
	logic [intWidth-1:0]        intMag;
	logic                       lostBits;

	logic                       isNan;
	logic                       isMinInt;
	logic signed [intWidth-1:0] intRes;
	cvtFlags_t                  intFlags;

	assign opSign = operand.sign;
	assign opExp  = operand.exp;
	assign opSig  = operand.sig;

	assign isNan = (int'(opExp) == expMax) && (opSig != '0);

	// Only meaningful for exponents from expBias up to topExp
	assign shiftAmt = 6'(int'(opExp) - expBias);
	assign fixedVal = 64'({1'b1, opSig}) << shiftAmt;

	// Integer part sits above the fraction bits and the rest is shifted out
	assign intMag   = fixedVal[FMSB + 1 +: intWidth];
	assign lostBits = |fixedVal[FMSB:0];

	// At topExp only the negative power of two itself still fits
	assign isMinInt = opSign && (intMag == minNeg);

	// ========================================
	// Conversion
	// ========================================

	always_comb begin
		intRes   = '0;
		intFlags = '0;
		if (isNan) begin
			intRes           = maxPos;
			intFlags.invalid = 1'b1;
		end else if (opExp < expBias) begin
			// Below one truncates to zero
			intFlags.inexact = (opExp != '0) || (opSig != '0);
		end else if ((opExp < topExp) || ((opExp == topExp) && isMinInt)) begin
			intRes           = opSign ? -intMag : intMag;
			intFlags.inexact = lostBits;
		end else begin
			// Too large or infinite, so the result clamps by sign
			intRes            = opSign ? minNeg : maxPos;
			intFlags.overflow = 1'b1;
		end
	end

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			out.vld <= 1'b0;
		end else if (ce) begin
			out.vld <= inVld;
		end
	end

	// The signed cast widens with sign extension
	always_ff @(posedge clk) begin
		if (ce && inVld) begin
			out.res   <= resWidth'(intRes);
			out.flags <= intFlags;
			out.op    <= op;
		end
	end

	// A NaN is never also reported as a clamp
	flagsExclusive: assert property (@(posedge clk) disable iff (rst)
		out.vld |-> !(out.flags.overflow && out.flags.invalid))
		else $error("integer path raised overflow and invalid together");

endmodule

`default_nettype wire

/* hw/cvtCombine.sv */
// Combining stage that picks the requested path, registers the result and keeps sticky flags
`default_nettype none

module cvtCombine import cvtPkg::*; #(
	parameter int intWidth = 32
) (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          ce,
	input  wire logic          clrFlags,
	cvtResultIf.dst            truncIn,
	cvtResultIf.dst            intIn,
	output logic               outVld,
	output logic [resWidth-1:0] result,
	output cvtFlags_t          resFlags,
	output cvtFlags_t          stickyFlags
);

	logic [resWidth-1:0] selRes;
	cvtFlags_t           selFlags;
	cvtFlags_t           stickyBase;

	// Both paths carry the same tag, so the truncation side decides
	always_comb begin
		if (truncIn.op == opToInt) begin
			selRes   = intIn.res;
			selFlags = intIn.flags;
		end else begin
			selRes   = truncIn.res;
			selFlags = truncIn.flags;
		end
	end

	// Clearing happens first so a flag arriving in the same cycle survives
	always_comb begin
		stickyBase = stickyFlags;
		if (clrFlags) begin
			stickyBase = '0;
		end
	end

	// ========================================
	// Control and sticky status
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			outVld      <= 1'b0;
			stickyFlags <= '0;
		end else if (ce) begin
			outVld <= truncIn.vld;
			if (truncIn.vld) begin
				stickyFlags <= cvtFlags_t'(stickyBase | selFlags);
			end else begin
				stickyFlags <= stickyBase;
			end
		end
	end

	// Result payload
	always_ff @(posedge clk) begin
		if (ce && truncIn.vld) begin
			result   <= selRes;
			resFlags <= selFlags;
		end
	end

	// ========================================
	// Checks
	// ========================================

	// Both paths were fed the same strobe and tag, so they stay in lockstep
	pathsInStep: assert property (@(posedge clk) disable iff (rst)
		(truncIn.vld == intIn.vld) && (!truncIn.vld || (truncIn.op == intIn.op)))
		else $error("conversion paths out of step");

	// A stall must not create a new output pulse
	holdOnStall: assert property (@(posedge clk) disable iff (rst)
		(!ce && !outVld) |=> !outVld)
		else $error("outVld rose after a disabled cycle");

	// The integer word above bit intWidth-1 is pure sign extension
	intSignExt: assert property (@(posedge clk) disable iff (rst)
		intIn.vld |-> ((intIn.res[resWidth-1:intWidth-1] == '0)
			|| (&intIn.res[resWidth-1:intWidth-1])))
		else $error("integer result not sign extended");

endmodule

`default_nettype wire

/* hw/fpCvtUnit.sv */
// Float conversion unit top that runs truncation and integer conversion side by side
`default_nettype none

module fpCvtUnit import cvtPkg::*; #(
	parameter int intWidth = 32
) (
	input  wire logic          clk,
	input  wire logic          rst,
	input  wire logic          ce,
	input  wire logic          inVld,
	input  wire cvtOp_e        op,
	input  wire logic [31:0]   operand,
	input  wire logic          clrFlags,
	output logic               outVld,
	output logic [31:0]        result,
	output cvtFlags_t          resFlags,
	output cvtFlags_t          stickyFlags
);

	// ========================================
	// Path result buses
	// ========================================

	cvtResultIf truncBus ();
	cvtResultIf intBus ();

	// Float truncation, one enabled cycle of latency
	fpTrunc32 i_fpTrunc32 (
		.clk     (clk),
		.rst     (rst),
		.ce      (ce),
		.inVld   (inVld),
		.op      (op),
		.operand (operand),
		.out     (truncBus.src)
	);

	// Integer conversion, same latency as the truncation path
	fpToInt #(
		.intWidth (intWidth)
	) i_fpToInt (
		.clk     (clk),
		.rst     (rst),
		.ce      (ce),
		.inVld   (inVld),
		.op      (op),
		.operand (operand),
		.out     (intBus.src)
	);

	// Selects by tag and adds the second register stage
	cvtCombine #(
		.intWidth (intWidth)
	) i_cvtCombine (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.clrFlags    (clrFlags),
		.truncIn     (truncBus.dst),
		.intIn       (intBus.dst),
		.outVld      (outVld),
		.result      (result),
		.resFlags    (resFlags),
		.stickyFlags (stickyFlags)
	);

endmodule

`default_nettype wire

/* tb/fpCvtModel.svh */
// Reference model of the conversion unit with the LFSR and special operand table for the testbench
`ifndef FPCVTMODEL_SVH
`define FPCVTMODEL_SVH

// ========================================
// Random source
// ========================================

// Galois LFSR over x^32 + x^22 + x^2 + x + 1, shifting right
// The bit that leaves at position zero is the random bit that is taken
function automatic logic [31:0] lfsrNext(input logic [31:0] state);
	logic [31:0] nextState;
	nextState = state >> 1;
	if (state[0]) begin
		nextState = nextState ^ 32'h80200003;
	end
	return nextState;
endfunction

// Operands that random exponents rarely or never reach
function automatic logic [31:0] specialValue(input logic [2:0] idx);
	logic [31:0] val;
	case (idx)
		3'd0:    val = 32'hCF000000; // Exactly -2^31
		3'd1:    val = 32'h4F000000; // +2^31, one past the largest integer
		3'd2:    val = 32'h7F800000;
		3'd3:    val = 32'hFF800000;
		3'd4:    val = 32'h7FC00000;
		3'd5:    val = 32'hFFFFFFFF; // NaN with the sign set
		3'd6:    val = 32'h00000001; // Smallest denormal
		default: val = 32'h80000000;
	endcase
	return val;
endfunction

// ========================================
// Conversion rules
// ========================================

// Both model functions return the flags in bits 34 to 32 as invalid, overflow, inexact
// and the 32-bit result word below them

// Truncation toward zero in float format
function automatic logic [34:0] truncModel(input logic [31:0] a);
	int          e;
	logic [22:0] lost;
	logic [31:0] r;
	logic [2:0]  f;
	e = a[30:23];
	r = a;
	f = 3'b000;
	if (e < 127) begin
		// Anything nonzero below one is lost entirely
		r    = {a[31], 31'b0};
		f[0] = a[30:0] != 0;
	end else if (e <= 150) begin
		// Exponent e leaves 150 - e fraction bits below the binary point
		lost    = a[22:0] & 23'((32'd1 << (150 - e)) - 32'd1);
		r[22:0] = a[22:0] & ~lost;
		f[0]    = lost != 0;
	end else begin
		f[2] = (e == 255) && (a[22:0] != 0);
	end
	return {f, r};
endfunction

// Conversion to a signed integer of w bits, sign extended to 32 bits
function automatic logic [34:0] intModel(input logic [31:0] a, input int w);
	int          e;
	int          p;
	logic [23:0] m;
	logic [23:0] lowMask;
	longint      maxPos;
	longint      mag;
	longint      v;
	logic [2:0]  f;
	e      = a[30:23];
	p      = e - 127;
	m      = {1'b1, a[22:0]};
	maxPos = (longint'(1) << (w - 1)) - 1;
	v      = 0;
	f      = 3'b000;
	if ((e == 255) && (a[22:0] != 0)) begin
		v    = maxPos;
		f[2] = 1'b1;
	end else if (e < 127) begin
		f[0] = a[30:0] != 0;
	end else if ((p > w - 1) || ((p == w - 1) && !(a[31] && (a[22:0] == 0)))) begin
		// Only -2^(w-1) survives at the top exponent
		v    = a[31] ? -maxPos - 1 : maxPos;
		f[1] = 1'b1;
	end else begin
		if (p >= 23) begin
			mag = longint'(m) << (p - 23);
		end else begin
			lowMask = (24'd1 << (23 - p)) - 24'd1;
			mag     = longint'(m >> (23 - p));
			f[0]    = (m & lowMask) != 0;
		end
		v = a[31] ? -mag : mag;
	end
	return {f, v[31:0]};
endfunction

`endif

/* tb/fpCvtUnitTb.sv */
// Testbench for the float conversion unit with random operands checked against a reference model
`default_nettype none

module fpCvtUnitTb import cvtPkg::*; ();

	localparam int intW       = 32;
	localparam int clkPeriod  = 4;
	localparam int resetLen   = 16;
	localparam int numOps     = 400;
	localparam int burstLen   = 40;
	localparam int watchdogTime = (numOps * 8 + resetLen) * clkPeriod;

	logic        clk;
	logic        rst;
	logic        ce;
	logic        inVld;
	cvtOp_e      op;
	logic [31:0] operand;
	logic        clrFlags;
	logic        outVld;
	logic [31:0] result;
	cvtFlags_t   resFlags;
	cvtFlags_t   stickyFlags;

	// Scoreboard queues hold one entry per operand in flight
	logic [34:0] expQ [$];
	int          edgeQ [$];
	int          cycQ [$];
	logic [2:0]  stickyModel;
	logic [31:0] lfsrState;
	int          enEdges;
	int          cycles;
	int          offered;
	int          checked;
	int          valErrors;
	int          otherErrors;
	logic        inBurst;

	`include "fpCvtModel.svh"

	fpCvtUnit #(
		.intWidth (intW)
	) i_fpCvtUnit (
		.clk         (clk),
		.rst         (rst),
		.ce          (ce),
		.inVld       (inVld),
		.op          (op),
		.operand     (operand),
		.clrFlags    (clrFlags),
		.outVld      (outVld),
		.result      (result),
		.resFlags    (resFlags),
		.stickyFlags (stickyFlags)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// ========================================
	// Stimulus helpers
	// ========================================

	// Builds a value from n LFSR bits with one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v         = {v[30:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
		return v;
	endfunction

	// Mostly exponents 120 to 160, which straddle one and the 32-bit integer limit
	function automatic logic [31:0] pickOperand();
		logic [31:0] a;
		if (takeBits(3) == 0) begin
			a = specialValue(3'(takeBits(3)));
		end else begin
			a[31]    = takeBits(1) != 0;
			a[30:23] = 8'(120 + takeBits(8) % 41);
			a[22:0]  = 23'(takeBits(23));
		end
		return a;
	endfunction

	task automatic driveRandom(input logic burst);
		if (burst) begin
			ce    = 1'b1;
			inVld = 1'b1;
		end else begin
			ce    = takeBits(2) != 0;
			inVld = takeBits(1) != 0;
		end
		op       = (takeBits(1) != 0) ? opToInt : opTrunc;
		operand  = pickOperand();
		clrFlags = takeBits(3) == 0;
		if (ce && inVld) begin
			offered++;
		end
	endtask

	task automatic driveIdle();
		ce       = 1'b1;
		inVld    = 1'b0;
		clrFlags = 1'b0;
	endtask

	// ========================================
	// Scoreboard
	// ========================================

	// Runs at the falling edge and replays the rising edge just passed
	// The inputs still hold the values that edge sampled
	task automatic checkEdge();
		logic [34:0] expItem;
		int          accEdge;
		int          accCyc;
		if (rst) begin
			assert (outVld == 1'b0) else begin
				valErrors++;
				$display("** Error: outVld = %h, expected %h during reset", outVld, 1'b0);
			end
			assert (stickyFlags == 3'b000) else begin
				valErrors++;
				$display("** Error: stickyFlags = %h, expected %h during reset",
					stickyFlags, 3'b000);
			end
		end else if (ce) begin
			enEdges++;
			if (clrFlags) begin
				stickyModel = 3'b000;
			end
			if (outVld) begin
				assert (expQ.size() != 0) else begin
					otherErrors++;
					$display("Output pulse seen with no operand in flight");
				end
			end
			if (outVld && (expQ.size() != 0)) begin
				expItem = expQ.pop_front();
				accEdge = edgeQ.pop_front();
				accCyc  = cycQ.pop_front();
				checked++;
				assert (result == expItem[31:0]) else begin
					valErrors++;
					$display("** Error: result = %h, expected %h for operand accepted in cycle %0d",
						result, expItem[31:0], accCyc);
				end
				assert (resFlags == expItem[34:32]) else begin
					valErrors++;
					$display("** Error: resFlags = %h, expected %h", resFlags, expItem[34:32]);
				end
				// The output loaded at this edge is sampled at the next enabled edge
				assert (enEdges + 1 - accEdge == 2) else begin
					otherErrors++;
					$display("Result came %0d enabled cycles after acceptance instead of two",
						enEdges + 1 - accEdge);
				end
				// Burst operands see no stall, so two enabled cycles are two clock cycles
				assert ((accCyc < 0) || (cycles + 1 - accCyc == 2)) else begin
					otherErrors++;
					$display("Burst result came %0d clock cycles after acceptance",
						cycles + 1 - accCyc);
				end
				stickyModel = stickyModel | expItem[34:32];
			end
			assert (stickyFlags == stickyModel) else begin
				valErrors++;
				$display("** Error: stickyFlags = %h, expected %h", stickyFlags, stickyModel);
			end
			if (inVld) begin
				expQ.push_back((op == opToInt) ? intModel(operand, intW) : truncModel(operand));
				edgeQ.push_back(enEdges);
				cycQ.push_back(inBurst ? cycles : -1);
			end
		end
	endtask

	task automatic nextCycle();
		@(negedge clk);
		cycles++;
		checkEdge();
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		lfsrState   = 32'd7;
		rst         = 1'b1;
		ce          = 1'b0;
		inVld       = 1'b0;
		op          = opTrunc;
		operand     = '0;
		clrFlags    = 1'b0;
		stickyModel = 3'b000;
		enEdges     = 0;
		cycles      = 0;
		offered     = 0;
		checked     = 0;
		valErrors   = 0;
		otherErrors = 0;
		inBurst     = 1'b1;
		repeat (resetLen) nextCycle();
		rst = 1'b0;
		// Back-to-back operands with ce held high
		repeat (burstLen) begin
			driveRandom(1'b1);
			nextCycle();
		end
		driveIdle();
		repeat (4) nextCycle();
		inBurst = 1'b0;
		while (offered < numOps) begin
			driveRandom(1'b0);
			nextCycle();
		end
		driveIdle();
		while (expQ.size() != 0) nextCycle();
		// A few spare cycles catch a duplicated output pulse
		repeat (4) nextCycle();
		$display("Checked %0d results with %0d value errors and %0d other errors",
			checked, valErrors, otherErrors);
		if ((valErrors == 0) && (otherErrors == 0) && (checked == numOps)) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Ends a stuck run
	initial begin
		#(watchdogTime);
		$display("Run timed out with %0d of %0d results checked", checked, numOps);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* fpCvtUnit.f */
+incdir+tb
hw/fp32Pkg.sv
hw/cvtPkg.sv
hw/cvtResultIf.sv
hw/fpTrunc32.sv
hw/fpToInt.sv
hw/cvtCombine.sv
hw/fpCvtUnit.sv
tb/fpCvtUnitTb.sv

/* Bender.yml */
package:
  name: fpCvtUnit

sources:
  - hw/fp32Pkg.sv
  - hw/cvtPkg.sv
  - hw/cvtResultIf.sv
  - hw/fpTrunc32.sv
  - hw/fpToInt.sv
  - hw/cvtCombine.sv
  - hw/fpCvtUnit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/fpCvtUnitTb.sv
